// ==== verilog.f ====
sprdma_pkg.sv
beam_counter.sv
sprdma_engine.sv
chip_bus_arbiter.sv
chip_ram.sv
sprdma_top.sv
tb_sprdma.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sprdma -f verilog.f -o tb_sprdma
./obj_dir/tb_sprdma > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	exit 1
fi
exit 0

// ==== tb_sprdma.sv ====
`timescale 1ns/1ps

module tb_sprdma;

	logic clk;
	logic rst_n;
	logic ecs;
	logic cpu_req;
	logic cpu_we;
	logic cpu_reg;
	sprdma_pkg::chip_addr_t cpu_address;
	sprdma_pkg::word_t cpu_wdata;
	logic cpu_ack;
	sprdma_pkg::word_t cpu_rdata;
	logic reg_wr;
	sprdma_pkg::reg_addr_t reg_address;
	sprdma_pkg::word_t reg_data;
	sprdma_pkg::hpos_t hpos;
	sprdma_pkg::vpos_t vpos;

	// reference model state
	sprdma_pkg::word_t m_mem [4096];
	sprdma_pkg::chip_addr_t m_pt [8];
	logic [9:0] m_vstart [8];
	logic [9:0] m_vstop [8];
	logic [7:0] m_active;
	logic [7:0] m_stop;
	logic m_en;
	sprdma_pkg::sprite_t m_spr;
	sprdma_pkg::hpos_t m_h; // beam model
	sprdma_pkg::vpos_t m_v;

	int n_checks;
	int n_errors;
	int pos_fetches;
	int data_fetches;

	sprdma_pkg::chip_addr_t test_addr [32];
	int exp_data_fetches;

	sprdma_top u_sprdma_top
	(
		.clk(clk),
		.rst_n(rst_n),
		.ecs(ecs),
		.cpu_req(cpu_req),
		.cpu_we(cpu_we),
		.cpu_reg(cpu_reg),
		.cpu_address(cpu_address),
		.cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.reg_wr(reg_wr),
		.reg_address(reg_address),
		.reg_data(reg_data),
		.hpos(hpos),
		.vpos(vpos)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_word(input string name, input sprdma_pkg::word_t exp,
		input sprdma_pkg::word_t act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("Fail %s: expected %h, actual %h (line %0d, h %0d)", name, exp, act,
				vpos, hpos);
		end
	endtask

	task automatic check_reg(input string name, input sprdma_pkg::reg_addr_t exp,
		input sprdma_pkg::reg_addr_t act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("Fail %s: expected %h, actual %h (line %0d, h %0d)", name, exp, act,
				vpos, hpos);
		end
	endtask

	task automatic check_addr(input string name, input sprdma_pkg::chip_addr_t exp,
		input sprdma_pkg::chip_addr_t act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_hpos(input string name, input sprdma_pkg::hpos_t exp,
		input sprdma_pkg::hpos_t act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_vpos(input string name, input sprdma_pkg::vpos_t exp,
		input sprdma_pkg::vpos_t act);
		n_checks++;
		if (exp !== act)
		begin
			n_errors++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (n_errors == errors_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, n_errors - errors_before);
	endtask

	// one cpu access, held until ack; checks the ack latency
	task automatic cpu_access(input logic we, input logic rg, input sprdma_pkg::chip_addr_t a,
		input sprdma_pkg::word_t d, input int exp_cycles, output sprdma_pkg::word_t rd);
		int n;
		logic acked;
		n = 0;
		acked = 1'b0;
		rd = '0;
		@(posedge clk);
		cpu_req <= 1'b1;
		cpu_we <= we;
		cpu_reg <= rg;
		cpu_address <= a;
		cpu_wdata <= d;
		while (!acked)
		begin
			@(negedge clk);
			n++;
			if (cpu_ack)
			begin
				acked = 1'b1;
				rd = cpu_rdata;
			end
			else if (n >= 8)
				abort_run("no cpu_ack within 8 cycles");
		end
		@(posedge clk);
		cpu_req <= 1'b0;
		cpu_we <= 1'b0;
		cpu_reg <= 1'b0;
		n_checks++;
		if (n != exp_cycles)
		begin
			n_errors++;
			$display("Fail cpu ack latency: expected %0d, actual %0d", exp_cycles, n);
		end
	endtask

	task automatic ram_write(input logic [11:0] idx, input sprdma_pkg::word_t d);
		sprdma_pkg::word_t unused;
		cpu_access(1'b1, 1'b0, {8'($urandom), idx}, d, 1, unused);
	endtask

	task automatic reg_write(input sprdma_pkg::reg_addr_t ra, input sprdma_pkg::word_t d);
		sprdma_pkg::word_t unused;
		cpu_access(1'b1, 1'b1, {12'h000, ra}, d, 1, unused);
	endtask

	task automatic wait_beam(input int line, input int h);
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > 100000)
				abort_run("beam position never reached");
		end
		while (!(vpos == sprdma_pkg::vpos_t'(line) && hpos == sprdma_pkg::hpos_t'(h)));
	endtask

	function automatic logic line_hit(input logic [9:0] target, input logic [10:0] line,
		input logic ext);
		logic [9:0] t;
		t = target;
		if (!ext)
			t[9] = 1'b0; // bit 9 ignored without ecs
		return t == line[9:0];
	endfunction

	function automatic sprdma_pkg::word_t make_ctl(input logic [9:0] vs, input logic [9:0] ve);
		logic [3:0] r;
		r = 4'($urandom);
		return {ve[7:0], r[3], vs[9], ve[9], r[2:1], vs[8], ve[8], r[0]};
	endfunction

	// register bus snoop into the model
	task automatic snoop(input sprdma_pkg::reg_addr_t a, input sprdma_pkg::word_t d);
		if (a[8:5] == 4'b1001)
		begin
			if (!a[1])
				m_pt[a[4:2]][20:16] = d[4:0];
			else
				m_pt[a[4:2]][15:1] = d[15:1];
		end
		else if (a[8:6] == 3'b101 && a[2:1] == 2'b00)
			m_vstart[a[5:3]][7:0] = d[15:8];
		else if (a[8:6] == 3'b101 && a[2:1] == 2'b01)
		begin
			m_vstop[a[5:3]][7:0] = d[15:8];
			m_vstart[a[5:3]][9:8] = {d[6], d[2]};
			m_vstop[a[5:3]][9:8] = {d[5], d[1]};
		end
	endtask

	// cycle model of the fetch rules, sampled mid-cycle
	always @(negedge clk)
	begin
		logic vb;
		logic ve;
		logic exp_wr;
		logic hit_start;
		logic hit_stop;
		sprdma_pkg::reg_addr_t exp_a;
		sprdma_pkg::word_t exp_d;
		sprdma_pkg::sprite_t s;
		if (rst_n)
		begin
			check_hpos("hpos", m_h, hpos);
			check_vpos("vpos", m_v, vpos);
			vb = vpos < 11'd25;
			ve = vpos == 11'd24;
			s = m_spr;
			exp_wr = 1'b0;
			exp_a = 8'hff;
			exp_d = '0;
			if (m_en && hpos[1:0] == 2'b01)
			begin
				if (ve || (m_stop[s] && !vb))
				begin
					exp_wr = 1'b1;
					exp_a = {3'b101, s, 1'b0, ~hpos[2]};
				end
				else if (m_active[s])
				begin
					exp_wr = 1'b1;
					exp_a = {3'b101, s, 1'b1, ~hpos[2]};
				end
				if (exp_wr)
				begin
					exp_d = m_mem[m_pt[s][12:1]];
					m_pt[s] = m_pt[s] + 1'b1;
				end
			end
			if (!exp_wr && cpu_ack && cpu_we && cpu_reg)
			begin
				exp_wr = 1'b1;
				exp_a = cpu_address[8:1];
				exp_d = cpu_wdata;
			end
			check_word("reg_wr", {15'h0, exp_wr}, {15'h0, reg_wr});
			check_reg("reg_address", exp_a, reg_address);
			if (exp_wr)
				check_word("reg_data", exp_d, reg_data);
			// sprite fetches seen on the bus
			if (reg_wr && !cpu_ack && reg_address[8:6] == 3'b101)
			begin
				if (reg_address[2])
					data_fetches++;
				else
					pos_fetches++;
			end
			// flags see the old pos/ctl values
			if (hpos[2:0] == 3'b010)
			begin
				hit_start = line_hit(m_vstart[s], vpos, ecs);
				hit_stop = line_hit(m_vstop[s], vpos, ecs);
				if (vb || hit_stop)
					m_active[s] = 1'b0;
				else if (hit_start)
					m_active[s] = 1'b1;
				m_stop[s] = hit_stop;
			end
			if (exp_wr)
				snoop(exp_a, exp_d);
			if (cpu_ack && cpu_we && !cpu_reg)
				m_mem[cpu_address[12:1]] = cpu_wdata;
			if (hpos[8:1] == 8'h18 && hpos[0])
				m_en = 1'b1;
			else if (hpos[8:1] == 8'h38 && hpos[0])
				m_en = 1'b0;
			if (hpos[2:0] == 3'b001)
				m_spr = {hpos[5] ^ hpos[4], ~hpos[4], hpos[3]};
			// 227 cycles a line, 313 lines a frame
			if (m_h == 9'd226)
			begin
				m_h = '0;
				if (m_v == 11'd312)
					m_v = '0;
				else
					m_v = m_v + 1'b1;
			end
			else
				m_h = m_h + 1'b1;
		end
		else
		begin
			m_h = '0;
			m_v = '0;
		end
	end

	initial
	begin
		int e0;
		int vs1;
		int ve1;
		int vs2;
		int ve2;
		logic [11:0] w;
		sprdma_pkg::chip_addr_t p;
		sprdma_pkg::word_t rd;
		void'($urandom(32'hfbec322e));
		rst_n = 1'b0;
		ecs = 1'b0;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_reg = 1'b0;
		cpu_address = '0;
		cpu_wdata = '0;
		n_checks = 0;
		n_errors = 0;
		pos_fetches = 0;
		data_fetches = 0;
		exp_data_fetches = 0;
		m_active = '0;
		m_stop = '0;
		m_en = 1'b0;
		m_spr = '0;
		for (int i = 0; i < 8; i++)
		begin
			m_vstart[i] = '0;
			m_vstop[i] = '0;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		ecs <= 1'($urandom);

		// cpu writes then reads in the upper half of ram
		e0 = n_errors;
		for (int i = 0; i < 32; i++)
		begin
			test_addr[i] = {8'($urandom), 1'b1, 11'($urandom)};
			cpu_access(1'b1, 1'b0, test_addr[i], 16'($urandom), 1, rd);
		end
		for (int i = 0; i < 32; i++)
		begin
			cpu_access(1'b0, 1'b0, test_addr[i], 16'($urandom), 1, rd);
			check_word("cpu read", m_mem[test_addr[i][12:1]], rd);
		end
		report_test("cpu chip ram", e0);

		// sprite blocks, two sprites per channel then an end marker
		e0 = n_errors;
		for (int s = 0; s < 8; s++)
		begin
			reg_write({3'b101, 3'(s), 2'b00}, 16'h0000);
			reg_write({3'b101, 3'(s), 2'b01}, 16'h0000);
			w = 12'(s * 64);
			vs1 = 30 + int'($urandom % 31);
			ve1 = vs1 + 3 + int'($urandom % 6);
			vs2 = ve1 + 2 + int'($urandom % 4);
			ve2 = vs2 + 3 + int'($urandom % 6);
			exp_data_fetches += 2 * (ve1 - vs1 + ve2 - vs2);
			ram_write(w, {8'(vs1), 8'($urandom)});
			ram_write(w + 12'd1, make_ctl(10'(vs1), 10'(ve1)));
			w = w + 12'd2;
			for (int i = 0; i < 2 * (ve1 - vs1); i++)
				ram_write(w + 12'(i), 16'($urandom));
			w = w + 12'(2 * (ve1 - vs1));
			ram_write(w, {8'(vs2), 8'($urandom)});
			ram_write(w + 12'd1, make_ctl(10'(vs2), 10'(ve2)));
			w = w + 12'd2;
			for (int i = 0; i < 2 * (ve2 - vs2); i++)
				ram_write(w + 12'(i), 16'($urandom));
			w = w + 12'(2 * (ve2 - vs2));
			ram_write(w, {8'h00, 8'($urandom)});
			ram_write(w + 12'd1, make_ctl({1'($urandom), 9'h000}, {1'($urandom), 9'h000}));
			p = {8'($urandom), 12'(s * 64)}; // upper bits wrap
			reg_write({4'b1001, 3'(s), 1'b0}, {11'h000, p[20:16]});
			reg_write({4'b1001, 3'(s), 1'b1}, {p[15:1], 1'b0});
			@(negedge clk);
			check_addr("sprite pointer", p, u_sprdma_top.u_sprdma_engine.sprpt[s]);
		end
		if (vpos >= 11'd24)
		begin
			n_errors++;
			$display("setup ran into the blanking fetch line");
		end
		report_test("pointer setup", e0);

		// read landing on the first slot of line 24
		e0 = n_errors;
		wait_beam(24, 9'h34);
		cpu_access(1'b0, 1'b0, test_addr[5], 16'h0000, 2, rd);
		check_word("contended read", m_mem[test_addr[5][12:1]], rd);
		report_test("slot contention", e0);

		e0 = n_errors;
		wait_beam(100, 0);
		check_word("pos/ctl fetches", 16'd48, 16'(pos_fetches));
		check_word("data fetches", 16'(exp_data_fetches), 16'(data_fetches));
		report_test("frame fetch", e0);

		$display("checks %0d, passed %0d, failed %0d", n_checks, n_checks - n_errors, n_errors);
		if (n_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== sprdma_top.sv ====
`timescale 1ns/1ps

module sprdma_top
(
	input logic clk,
	input logic rst_n,
	input logic ecs,
	input logic cpu_req,
	input logic cpu_we,
	input logic cpu_reg,
	input sprdma_pkg::chip_addr_t cpu_address,
	input sprdma_pkg::word_t cpu_wdata,
	output logic cpu_ack,
	output sprdma_pkg::word_t cpu_rdata,
	output logic reg_wr,
	output sprdma_pkg::reg_addr_t reg_address,
	output sprdma_pkg::word_t reg_data,
	output sprdma_pkg::hpos_t hpos,
	output sprdma_pkg::vpos_t vpos
);

	logic vbl;
	logic vblend;
	logic dma_req;
	logic dma_ack;
	sprdma_pkg::reg_addr_t dma_reg_address;
	sprdma_pkg::chip_addr_t dma_address;
	sprdma_pkg::chip_addr_t ram_address;
	logic ram_we;
	sprdma_pkg::word_t ram_wdata;
	sprdma_pkg::word_t ram_rdata;

	beam_counter u_beam_counter
	(
		.clk(clk),
		.rst_n(rst_n),
		.hpos(hpos),
		.vpos(vpos),
		.vbl(vbl),
		.vblend(vblend)
	);

	// engine snoops the shared register bus
	sprdma_engine u_sprdma_engine
	(
		.clk(clk),
		.rst_n(rst_n),
		.ecs(ecs),
		.hpos(hpos),
		.vpos(vpos),
		.vbl(vbl),
		.vblend(vblend),
		.dma_req(dma_req),
		.dma_ack(dma_ack),
		.dma_reg_address(dma_reg_address),
		.dma_address(dma_address),
		.reg_address(reg_address),
		.reg_data(reg_data)
	);

	chip_bus_arbiter u_chip_bus_arbiter
	(
		.clk(clk),
		.rst_n(rst_n),
		.dma_req(dma_req),
		.dma_ack(dma_ack),
		.dma_reg_address(dma_reg_address),
		.dma_address(dma_address),
		.cpu_req(cpu_req),
		.cpu_we(cpu_we),
		.cpu_reg(cpu_reg),
		.cpu_address(cpu_address),
		.cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.ram_address(ram_address),
		.ram_we(ram_we),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.reg_wr(reg_wr),
		.reg_address(reg_address),
		.reg_data(reg_data)
	);

	chip_ram u_chip_ram
	(
		.clk(clk),
		.address(ram_address),
		.we(ram_we),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

// ==== chip_ram.sv ====
`timescale 1ns/1ps

module chip_ram
(
	input logic clk,
	input sprdma_pkg::chip_addr_t address,
	input logic we,
	input sprdma_pkg::word_t wdata,
	output sprdma_pkg::word_t rdata
);

	localparam int AW = sprdma_pkg::RAM_WORDS_LOG2;

	sprdma_pkg::word_t mem [2**AW];
	logic [AW-1:0] index;

	// upper address bits wrap
	assign index = address[AW:1];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[index] <= wdata;
	end

	assign rdata = mem[index]; // async read

endmodule

// ==== chip_bus_arbiter.sv ====
`timescale 1ns/1ps

module chip_bus_arbiter
(
	input logic clk,
	input logic rst_n,
	input logic dma_req,
	output logic dma_ack,
	input sprdma_pkg::reg_addr_t dma_reg_address,
	input sprdma_pkg::chip_addr_t dma_address,
	input logic cpu_req,
	input logic cpu_we,
	input logic cpu_reg,
	input sprdma_pkg::chip_addr_t cpu_address,
	input sprdma_pkg::word_t cpu_wdata,
	output logic cpu_ack,
	output sprdma_pkg::word_t cpu_rdata,
	output sprdma_pkg::chip_addr_t ram_address,
	output logic ram_we,
	output sprdma_pkg::word_t ram_wdata,
	input sprdma_pkg::word_t ram_rdata,
	output logic reg_wr,
	output sprdma_pkg::reg_addr_t reg_address,
	output sprdma_pkg::word_t reg_data
);

	logic ack_q; // cpu acked last cycle

	// sprite dma always wins
	assign dma_ack = dma_req;
	assign cpu_ack = cpu_req && !dma_req && !ack_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= cpu_ack;
	end

	assign ram_address = dma_ack ? dma_address : cpu_address;
	assign ram_we = cpu_ack && cpu_we && !cpu_reg;
	assign ram_wdata = cpu_wdata;
	assign cpu_rdata = ram_rdata; // valid in the ack cycle

	// custom register bus
	always_comb
	begin
		reg_wr = 1'b0;
		reg_address = sprdma_pkg::REG_NONE;
		reg_data = '0;
		if (dma_ack)
		begin
			reg_wr = 1'b1;
			reg_address = dma_reg_address;
			reg_data = ram_rdata;
		end
		else if (cpu_ack && cpu_we && cpu_reg)
		begin
			reg_wr = 1'b1;
			reg_address = cpu_address[8:1];
			reg_data = cpu_wdata;
		end
	end

endmodule

// ==== sprdma_engine.sv ====
`timescale 1ns/1ps

module sprdma_engine
(
	input logic clk,
	input logic rst_n,
	input logic ecs,
	input sprdma_pkg::hpos_t hpos,
	input sprdma_pkg::vpos_t vpos,
	input logic vbl,
	input logic vblend,
	output logic dma_req,
	input logic dma_ack,
	output sprdma_pkg::reg_addr_t dma_reg_address,
	output sprdma_pkg::chip_addr_t dma_address,
	input sprdma_pkg::reg_addr_t reg_address,
	input sprdma_pkg::word_t reg_data
);

	// per-sprite registers
	sprdma_pkg::chip_addr_t sprpt [sprdma_pkg::N_SPRITES];
	logic [7:0] sprpos [sprdma_pkg::N_SPRITES];  // vstart 7:0
	logic [11:0] sprctl [sprdma_pkg::N_SPRITES]; // vstop 7:0, vstart9, vstop9, vstart8, vstop8

	// per-sprite beam state
	logic [sprdma_pkg::N_SPRITES-1:0] dma_active;
	logic [sprdma_pkg::N_SPRITES-1:0] vstop_hit;

	sprdma_pkg::sprite_t sprite; // sprite owning the current slot pair
	sprdma_pkg::sprite_t pt_sel;
	sprdma_pkg::sprite_t pc_sel;
	logic enable;
	logic pt_wr;
	logic pc_wr;
	logic [9:0] vstart;
	logic [9:0] vstop;
	logic start_match;
	logic stop_match;
	logic slot;
	logic [1:0] word_sel;

	// register bus decode
	assign pt_wr = (reg_address[8:5] == sprdma_pkg::SPRPT_BASE[8:5]);
	assign pt_sel = reg_address[4:2];
	assign pc_wr = (reg_address[8:6] == sprdma_pkg::SPRPOSCTL_BASE[8:6]);
	assign pc_sel = reg_address[5:3];

	// pointers, dma increment wins over a bus write
	always_ff @(posedge clk)
	begin
		if (dma_ack)
			sprpt[sprite] <= dma_address + 1'b1;
		else if (pt_wr && !reg_address[1])
			sprpt[pt_sel][20:16] <= reg_data[4:0]; // high word
		else if (pt_wr)
			sprpt[pt_sel][15:1] <= reg_data[15:1];
	end

	assign dma_address = sprpt[sprite];

	// snooped pos/ctl copies
	always_ff @(posedge clk)
	begin
		if (pc_wr && reg_address[2:1] == sprdma_pkg::SEL_POS)
			sprpos[pc_sel] <= reg_data[15:8];
		if (pc_wr && reg_address[2:1] == sprdma_pkg::SEL_CTL)
			sprctl[pc_sel] <= {reg_data[15:8], reg_data[6], reg_data[5],
				reg_data[2], reg_data[1]};
	end

	assign vstart = {sprctl[sprite][3], sprctl[sprite][1], sprpos[sprite]};
	assign vstop = {sprctl[sprite][2], sprctl[sprite][0], sprctl[sprite][11:4]};
	assign start_match = sprdma_pkg::vmatch(vstart, vpos, ecs);
	assign stop_match = sprdma_pkg::vmatch(vstop, vpos, ecs);

	// vertical state, once per sprite group at hpos 010
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dma_active <= '0;
			vstop_hit <= '0;
		end
		else if (hpos[2:0] == 3'b010)
		begin
			if (vbl || stop_match)
				dma_active[sprite] <= 1'b0;
			else if (start_match)
				dma_active[sprite] <= 1'b1;
			vstop_hit[sprite] <= stop_match;
		end
	end

	// slot window
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			enable <= 1'b0;
		else if (hpos[8:1] == sprdma_pkg::SPR_WIN_START && hpos[0])
			enable <= 1'b1;
		else if (hpos[8:1] == sprdma_pkg::SPR_WIN_STOP && hpos[0])
			enable <= 1'b0;
	end

	// sprite order 0..7 across the window
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sprite <= '0;
		else if (hpos[2:0] == 3'b001)
			sprite <= {hpos[5] ^ hpos[4], ~hpos[4], hpos[3]};
	end

	assign slot = enable && (hpos[1:0] == 2'b01);

	always_comb
	begin
		dma_req = 1'b0;
		word_sel = hpos[2] ? sprdma_pkg::SEL_POS : sprdma_pkg::SEL_CTL;
		dma_reg_address = sprdma_pkg::REG_NONE;
		if (slot)
		begin
			if (vblend || (vstop_hit[sprite] && !vbl))
			begin
				dma_req = 1'b1; // next pos/ctl pair
				dma_reg_address = sprdma_pkg::sprposctl_addr(sprite, word_sel);
			end
			else if (dma_active[sprite])
			begin
				dma_req = 1'b1;
				word_sel = hpos[2] ? sprdma_pkg::SEL_DATA : sprdma_pkg::SEL_DATB;
				dma_reg_address = sprdma_pkg::sprposctl_addr(sprite, word_sel);
			end
		end
	end

endmodule

// ==== beam_counter.sv ====
`timescale 1ns/1ps

module beam_counter
(
	input logic clk,
	input logic rst_n,
	output sprdma_pkg::hpos_t hpos,
	output sprdma_pkg::vpos_t vpos,
	output logic vbl,
	output logic vblend
);

	logic line_end;
	logic frame_end;

	assign line_end = (hpos == sprdma_pkg::hpos_t'(sprdma_pkg::H_TOTAL - 1));
	assign frame_end = (vpos == sprdma_pkg::vpos_t'(sprdma_pkg::V_TOTAL - 1));

	// horizontal position, one step per clk
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hpos <= '0;
		else if (line_end)
			hpos <= '0;
		else
			hpos <= hpos + 1'b1;
	end

	// vertical position steps on line wrap
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vpos <= '0;
		else if (line_end)
		begin
			if (frame_end)
				vpos <= '0;
			else
				vpos <= vpos + 1'b1;
		end
	end

	assign vbl = (vpos < sprdma_pkg::vpos_t'(sprdma_pkg::VBL_LINES));
	assign vblend = (vpos == sprdma_pkg::vpos_t'(sprdma_pkg::VBL_LINES - 1)); // last blank line

endmodule

// ==== sprdma_pkg.sv ====
package sprdma_pkg;

	// beam and bus widths
	typedef logic [8:0] hpos_t;
	typedef logic [10:0] vpos_t;      // low 10 bits compared
	typedef logic [20:1] chip_addr_t; // chip ram word address
	typedef logic [15:0] word_t;
	typedef logic [8:1] reg_addr_t;   // custom register word address
	typedef logic [2:0] sprite_t;

	// beam timing, in clk cycles and lines
	localparam int H_TOTAL = 227;
	localparam int V_TOTAL = 313;
	localparam int VBL_LINES = 25;

	// sprite slot window, against hpos[8:1]
	localparam logic [7:0] SPR_WIN_START = 8'h18;
	localparam logic [7:0] SPR_WIN_STOP = 8'h38;

	localparam int N_SPRITES = 8;

	// register map
	localparam logic [8:0] SPRPT_BASE = 9'h120;     // pth, ptl per sprite
	localparam logic [8:0] SPRPOSCTL_BASE = 9'h140; // pos, ctl, data, datb per sprite
	localparam reg_addr_t REG_NONE = 8'hff;         // idle register bus

	// word select within a sprite's pos/ctl block
	localparam logic [1:0] SEL_POS = 2'b00;
	localparam logic [1:0] SEL_CTL = 2'b01;
	localparam logic [1:0] SEL_DATA = 2'b10;
	localparam logic [1:0] SEL_DATB = 2'b11;

	// chip ram size, upper pointer bits wrap
	localparam int RAM_WORDS_LOG2 = 12;

	// register address of one word in a sprite's pos/ctl/data block
	function automatic reg_addr_t sprposctl_addr(input sprite_t spr, input logic [1:0] sel);
		reg_addr_t addr;
		addr = {SPRPOSCTL_BASE[8:6], spr, sel};
		return addr;
	endfunction

	// register address of a sprite pointer word, hi = 1 for bits 20:16
	function automatic reg_addr_t sprpt_addr(input sprite_t spr, input logic hi);
		reg_addr_t addr;
		addr = {SPRPT_BASE[8:5], spr, ~hi};
		return addr;
	endfunction

	// vertical compare, bit 9 only counts with ecs
	function automatic logic vmatch(input logic [9:0] v, input vpos_t pos, input logic ecs);
		logic hit;
		hit = ({ecs & v[9], v[8:0]} == pos[9:0]);
		return hit;
	endfunction

endpackage
